// ==== camLaneTop.f ====
+incdir+verilog
verilog/camPkg.sv
verilog/laneConfig.sv
verilog/tagCamRam.sv
verilog/matchEncoder.sv
verilog/camLaneTop.sv
verif/tbCamLaneTop.sv

// ==== verif/tbCamLaneTop.sv ====
`timescale 1ns/10ps
`include "camRam_params.svh"

module tbCamLaneTop;

  localparam int TIMEOUT_CYCLES = 2000;  // About twice the full stimulus length
  localparam int RANDOM_CYCLES  = 800;

  logic                                clkGated;
  logic                                reset;
  logic                                cfgWrite;
  camPkg::laneCfg_t                    cfgData;
  camPkg::wrReq_t  [`CAM_WR_LANES-1:0] wrReq;
  camPkg::rdReq_t  [`CAM_RD_LANES-1:0] rdReq;
  camPkg::rdResp_t [`CAM_RD_LANES-1:0] rdResp;
  camPkg::laneCfg_t                    cfgState;
  logic                                cfgError;
  logic                                ramReady;

  // Reference model state
  logic [`CAM_WIDTH-1:0] modelMem [`CAM_DEPTH];
  camPkg::laneCfg_t      modelCfg;
  logic                  modelErr;

  int checkCount   = 0;
  int errorCount   = 0;
  int timeoutCount = 0;
  int cycleCount   = 0;

  camLaneTop UUT (
    .clkGated   (clkGated),
    .reset      (reset),
    .cfgWrite_i (cfgWrite),
    .cfgData_i  (cfgData),
    .wrReq_i    (wrReq),
    .rdReq_i    (rdReq),
    .rdResp_o   (rdResp),
    .cfgState_o (cfgState),
    .cfgError_o (cfgError),
    .ramReady_o (ramReady)
  );

  initial
  begin
    clkGated = 1'b0;
  end

  always #4 clkGated = ~clkGated;  // 8 ns period

  // Expected lookup response from the model state
  function automatic camPkg::rdResp_t expectResp(input int lane, input camPkg::rdReq_t req);
    camPkg::rdResp_t resp;
    resp = '0;
    if (modelCfg.rdLaneEn[lane])
    begin
      resp.data = modelMem[req.addr];
      for (int e = 0; e < `CAM_DEPTH; e++)
      begin
        if (!resp.hit && modelMem[e] == req.tag)
        begin
          resp.hit        = 1'b1;
          resp.matchIndex = `CAM_INDEX'(e);
        end
      end
    end
    return resp;
  endfunction

  // Model follows the DUT at each edge
  always @(posedge clkGated)
  begin
    if (reset)
    begin
      for (int k = 0; k < `CAM_DEPTH; k++)
      begin
        modelMem[k] = `CAM_WIDTH'(k);
      end
      modelCfg.wrLaneEn = '1;
      modelCfg.rdLaneEn = '1;
      modelErr          = 1'b0;
    end
    else
    begin
      // Lanes in ascending order so lane 1 wins a clash
      for (int w = 0; w < `CAM_WR_LANES; w++)
      begin
        if (wrReq[w].en && modelCfg.wrLaneEn[w])
        begin
          modelMem[wrReq[w].addr] = wrReq[w].data;
        end
      end
      modelErr = cfgWrite && (cfgData.rdLaneEn == '0);
      if (cfgWrite && (cfgData.rdLaneEn != '0))
      begin
        modelCfg = cfgData;
      end
    end
  end

  task automatic checkOutputs;
    camPkg::rdResp_t expResp;
    checkCount++;
    assert (ramReady == !reset)
    else
    begin
      errorCount++;
      $display("ERROR %0t: ramReady_o is %b while reset is %b", $time, ramReady, reset);
    end
    if (!reset)
    begin
      for (int r = 0; r < `CAM_RD_LANES; r++)
      begin
        expResp = expectResp(r, rdReq[r]);
        assert (rdResp[r] == expResp)
        else
        begin
          errorCount++;
          $display("ERROR %0t: lane %0d got hit=%b idx=%0d data=%h, want hit=%b idx=%0d data=%h",
                   $time, r, rdResp[r].hit, rdResp[r].matchIndex, rdResp[r].data,
                   expResp.hit, expResp.matchIndex, expResp.data);
        end
      end
      assert (cfgState == modelCfg)
      else
      begin
        errorCount++;
        $display("ERROR %0t: cfgState_o is %b, expected %b", $time, cfgState, modelCfg);
      end
      assert (cfgError == modelErr)
      else
      begin
        errorCount++;
        $display("ERROR %0t: cfgError_o is %b, expected %b", $time, cfgError, modelErr);
      end
    end
  endtask

  // Sample 1 ns before the next rising edge
  always
  begin
    @(posedge clkGated);
    #7;
    checkOutputs();
  end

  task automatic reportAndFinish;
    $display("Summary: %0d checks, %0d errors, %0d timeouts",
             checkCount, errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0)
    begin
      $display("TB PASSED");
    end
    else
    begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  always @(posedge clkGated)
  begin
    cycleCount++;
    if (cycleCount >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: the stimulus did not complete within %0d cycles", TIMEOUT_CYCLES);
      timeoutCount++;
      reportAndFinish();
    end
  end

  task automatic nextCycle;
    @(posedge clkGated);
    #1;  // Inputs change shortly after the edge
  endtask

  task automatic clearInputs;
    cfgWrite = 1'b0;
    cfgData  = '0;
    wrReq    = '0;
    rdReq    = '0;
  endtask

  task automatic writeLane(input int lane, input logic [`CAM_INDEX-1:0] addr,
                           input logic [`CAM_WIDTH-1:0] data);
    wrReq[lane].en   = 1'b1;
    wrReq[lane].addr = addr;
    wrReq[lane].data = data;
  endtask

  task automatic setLookup(input int lane, input logic [`CAM_WIDTH-1:0] tag,
                           input logic [`CAM_INDEX-1:0] addr);
    rdReq[lane].tag  = tag;
    rdReq[lane].addr = addr;
  endtask

  task automatic applyConfig(input logic [`CAM_WR_LANES-1:0] wrEn,
                             input logic [`CAM_RD_LANES-1:0] rdEn);
    cfgWrite         = 1'b1;
    cfgData.wrLaneEn = wrEn;
    cfgData.rdLaneEn = rdEn;
  endtask

  task automatic randomCycle;
    clearInputs();
    for (int w = 0; w < `CAM_WR_LANES; w++)
    begin
      wrReq[w].en   = 1'($urandom_range(0, 1));
      wrReq[w].addr = `CAM_INDEX'($urandom_range(0, `CAM_DEPTH - 1));
      wrReq[w].data = `CAM_WIDTH'($urandom_range(0, 23));  // Narrow range keeps hits frequent
    end
    for (int r = 0; r < `CAM_RD_LANES; r++)
    begin
      setLookup(r, `CAM_WIDTH'($urandom_range(0, 23)), `CAM_INDEX'($urandom_range(0, 15)));
    end
    if ($urandom_range(0, 15) == 0)
    begin
      applyConfig(`CAM_WR_LANES'($urandom_range(0, 3)), `CAM_RD_LANES'($urandom_range(1, 3)));
    end
    nextCycle();
  endtask

  initial
  begin
    void'($urandom(32'hb2a4));
    reset = 1'b1;
    clearInputs();
    repeat (5) nextCycle();
    reset = 1'b0;

    // Entry k holds tag k after reset
    for (int a = 0; a < `CAM_DEPTH; a++)
    begin
      setLookup(0, `CAM_WIDTH'(a), `CAM_INDEX'(a));
      setLookup(1, `CAM_WIDTH'(15 - a), `CAM_INDEX'(15 - a));
      nextCycle();
    end

    // Write visibility, lowest index and a missing tag
    clearInputs();
    writeLane(0, 4'd3, 6'h2A);
    setLookup(0, 6'h2A, 4'd3);  // Still the old contents this cycle
    nextCycle();
    clearInputs();
    setLookup(0, 6'h2A, 4'd3);
    setLookup(1, 6'h03, 4'd3);
    nextCycle();
    clearInputs();
    writeLane(0, 4'd12, 6'h2A);
    writeLane(1, 4'd9, 6'h2A);
    nextCycle();
    clearInputs();
    setLookup(0, 6'h2A, 4'd12);
    setLookup(1, 6'h3F, 4'd9);
    nextCycle();

    // Same address on both write lanes
    clearInputs();
    writeLane(0, 4'd5, 6'h11);
    writeLane(1, 4'd5, 6'h22);
    nextCycle();
    clearInputs();
    setLookup(0, 6'h22, 4'd5);
    setLookup(1, 6'h11, 4'd5);
    nextCycle();

    // Write lane 0 and read lane 1 switched off
    clearInputs();
    applyConfig(2'b10, 2'b01);
    nextCycle();
    clearInputs();
    writeLane(0, 4'd7, 6'h33);
    writeLane(1, 4'd8, 6'h34);
    setLookup(0, 6'h07, 4'd7);
    setLookup(1, 6'h07, 4'd7);
    nextCycle();
    clearInputs();
    setLookup(0, 6'h33, 4'd7);
    setLookup(1, 6'h34, 4'd8);
    nextCycle();
    setLookup(0, 6'h34, 4'd8);
    nextCycle();

    // A configuration with no lookup lane is rejected
    clearInputs();
    applyConfig(2'b11, 2'b00);
    nextCycle();
    clearInputs();
    nextCycle();
    nextCycle();
    applyConfig(2'b11, 2'b11);
    nextCycle();

    repeat (RANDOM_CYCLES) randomCycle();

    clearInputs();
    nextCycle();
    nextCycle();
    reportAndFinish();
  end

endmodule

// ==== verilog/camLaneTop.sv ====
`timescale 1ns/10ps
`include "camRam_params.svh"

module camLaneTop (
  input  logic                               clkGated,
  input  logic                               reset,
  input  logic                               cfgWrite_i,
  input  camPkg::laneCfg_t                   cfgData_i,
  input  camPkg::wrReq_t  [`CAM_WR_LANES-1:0] wrReq_i,
  input  camPkg::rdReq_t  [`CAM_RD_LANES-1:0] rdReq_i,
  output camPkg::rdResp_t [`CAM_RD_LANES-1:0] rdResp_o,
  output camPkg::laneCfg_t                   cfgState_o,
  output logic                               cfgError_o,
  output logic                               ramReady_o
);

  camPkg::laneCfg_t                           laneCfg;
  logic [`CAM_RD_LANES-1:0][`CAM_DEPTH-1:0]   hitVect;
  logic [`CAM_RD_LANES-1:0][`CAM_WIDTH-1:0]   rdData;

  // Lane enable register
  laneConfig laneConfigInst (
    .clkGated   (clkGated),
    .reset      (reset),
    .cfgWrite_i (cfgWrite_i),
    .cfgData_i  (cfgData_i),
    .laneCfg_o  (laneCfg),
    .cfgError_o (cfgError_o)
  );

  // Tag storage
  tagCamRam tagCamRamInst (
    .clkGated   (clkGated),
    .reset      (reset),
    .laneCfg_i  (laneCfg),
    .wrReq_i    (wrReq_i),
    .rdReq_i    (rdReq_i),
    .hitVect_o  (hitVect),
    .rdData_o   (rdData),
    .ramReady_o (ramReady_o)
  );

  // One encoder per lookup lane
  for (genvar r = 0; r < `CAM_RD_LANES; r++)
  begin : genRdLane
    matchEncoder matchEncoderInst (
      .hitVect_i    (hitVect[r]),
      .hit_o        (rdResp_o[r].hit),
      .matchIndex_o (rdResp_o[r].matchIndex)
    );

    assign rdResp_o[r].data = rdData[r];  // Read data bypasses the encoder
  end

  // Readback of the configuration in force
  assign cfgState_o = laneCfg;

endmodule

// ==== verilog/camPkg.sv ====
`include "camRam_params.svh"

package camPkg;

  // Write lane request
  typedef struct packed {
    logic                  en;    // Write strobe for this lane
    logic [`CAM_INDEX-1:0] addr;  // Entry to overwrite
    logic [`CAM_WIDTH-1:0] data;  // New tag value
  } wrReq_t;

  // Lookup lane request, search key plus read address
  typedef struct packed {
    logic [`CAM_WIDTH-1:0] tag;   // CAM search key
    logic [`CAM_INDEX-1:0] addr;  // RAM read address
  } rdReq_t;

  // Lookup lane response
  typedef struct packed {
    logic                  hit;         // Some entry holds the key
    logic [`CAM_INDEX-1:0] matchIndex;  // Lowest matching entry
    logic [`CAM_WIDTH-1:0] data;        // Contents at the read address
  } rdResp_t;

  // Lane enables, one bit per lane
  typedef struct packed {
    logic [`CAM_WR_LANES-1:0] wrLaneEn;
    logic [`CAM_RD_LANES-1:0] rdLaneEn;
  } laneCfg_t;

endpackage

// ==== verilog/camRam_params.svh ====
`ifndef CAMRAM_PARAMS_SVH
`define CAMRAM_PARAMS_SVH

// Tag store geometry

// One entry per physical register tag
`define CAM_DEPTH 16

// Enough bits to address every entry
`define CAM_INDEX 4

// Physical register tag width
`define CAM_WIDTH 6

// Lane counts

// Dispatch side writes
`define CAM_WR_LANES 2

// Each lookup lane has one CAM search and one RAM read
`define CAM_RD_LANES 2

`endif

// ==== verilog/laneConfig.sv ====
`timescale 1ns/10ps
`include "camRam_params.svh"

module laneConfig (
  input  logic              clkGated,
  input  logic              reset,
  input  logic              cfgWrite_i,
  input  camPkg::laneCfg_t  cfgData_i,
  output camPkg::laneCfg_t  laneCfg_o,
  output logic              cfgError_o
);

  camPkg::laneCfg_t cfgQ;
  logic             errorQ;
  logic             cfgValid;
  logic             cfgAccept;
  logic             cfgReject;

  // A configuration must leave at least one lookup lane alive
  assign cfgValid  = |cfgData_i.rdLaneEn;
  assign cfgAccept = cfgWrite_i & cfgValid;
  assign cfgReject = cfgWrite_i & ~cfgValid;

  // Lane enable register
  always_ff @(posedge clkGated)
  begin
    if (reset)
    begin
      cfgQ.wrLaneEn <= {`CAM_WR_LANES{1'b1}};  // All lanes on after reset
      cfgQ.rdLaneEn <= {`CAM_RD_LANES{1'b1}};
    end
    else if (cfgAccept)
    begin
      cfgQ <= cfgData_i;
    end
  end

  // Error flag lasts exactly one cycle per rejected write
  always_ff @(posedge clkGated)
  begin
    if (reset)
    begin
      errorQ <= 1'b0;
    end
    else
    begin
      errorQ <= cfgReject;
    end
  end

  assign laneCfg_o  = cfgQ;
  assign cfgError_o = errorQ;

endmodule

// ==== verilog/matchEncoder.sv ====
`timescale 1ns/10ps
`include "camRam_params.svh"

module matchEncoder (
  input  logic [`CAM_DEPTH-1:0] hitVect_i,
  output logic                  hit_o,
  output logic [`CAM_INDEX-1:0] matchIndex_o
);

  logic [`CAM_INDEX-1:0] lowIndex;

  // Any entry matching means a hit
  assign hit_o = |hitVect_i;

  // Lowest set bit wins
  // Scanning downward lets the lowest match overwrite the rest
  always_comb
  begin
    lowIndex = '0;  // Stays zero when nothing matches
    for (int i = `CAM_DEPTH - 1; i >= 0; i--)
    begin
      if (hitVect_i[i])
      begin
        lowIndex = `CAM_INDEX'(i);
      end
    end
  end

  assign matchIndex_o = lowIndex;

endmodule

// ==== verilog/tagCamRam.sv ====
`timescale 1ns/10ps
`include "camRam_params.svh"

module tagCamRam (
  input  logic                                          clkGated,
  input  logic                                          reset,
  input  camPkg::laneCfg_t                              laneCfg_i,
  input  camPkg::wrReq_t [`CAM_WR_LANES-1:0]            wrReq_i,
  input  camPkg::rdReq_t [`CAM_RD_LANES-1:0]            rdReq_i,
  output logic [`CAM_RD_LANES-1:0][`CAM_DEPTH-1:0]      hitVect_o,
  output logic [`CAM_RD_LANES-1:0][`CAM_WIDTH-1:0]      rdData_o,
  output logic                                          ramReady_o
);

  logic [`CAM_WIDTH-1:0]    ramReg [`CAM_DEPTH];
  logic [`CAM_WR_LANES-1:0] writeEn;
  logic [`CAM_WR_LANES-1:0][`CAM_INDEX-1:0] writeAddr;
  logic [`CAM_WR_LANES-1:0][`CAM_WIDTH-1:0] writeData;
  logic [`CAM_RD_LANES-1:0] readEn;

  // Unpack write lanes and drop requests on deconfigured lanes
  always_comb
  begin
    for (int w = 0; w < `CAM_WR_LANES; w++)
    begin
      writeEn[w]   = wrReq_i[w].en & laneCfg_i.wrLaneEn[w];
      writeAddr[w] = wrReq_i[w].addr;
      writeData[w] = wrReq_i[w].data;
    end
  end

  assign readEn = laneCfg_i.rdLaneEn;

  // Store is usable as soon as reset drops
  assign ramReady_o = ~reset;

  // Tag array with sequential reset so entry k starts as tag k
  always_ff @(posedge clkGated)
  begin
    if (reset)
    begin
      for (int k = 0; k < `CAM_DEPTH; k++)
      begin
        ramReg[k] <= `CAM_WIDTH'(k);
      end
    end
    else
    begin
      // Later lanes overwrite earlier ones on an address clash
      for (int w = 0; w < `CAM_WR_LANES; w++)
      begin
        if (writeEn[w])
        begin
          ramReg[writeAddr[w]] <= writeData[w];
        end
      end
    end
  end

  // Equality search, one hit vector per lookup lane
  always_comb
  begin
    for (int r = 0; r < `CAM_RD_LANES; r++)
    begin
      hitVect_o[r] = '0;  // Disabled lane reports no hits
      if (readEn[r])
      begin
        for (int e = 0; e < `CAM_DEPTH; e++)
        begin
          if (rdReq_i[r].tag == ramReg[e])
          begin
            hitVect_o[r][e] = 1'b1;
          end
        end
      end
    end
  end

  // Indexed read port per lookup lane
  always_comb
  begin
    for (int r = 0; r < `CAM_RD_LANES; r++)
    begin
      if (readEn[r])
      begin
        rdData_o[r] = ramReg[rdReq_i[r].addr];
      end
      else
      begin
        rdData_o[r] = '0;  // Keeps the response predictable
      end
    end
  end

endmodule
